// File: agc_pkg.sv
package agc_pkg;

  // Machine word and address widths
  typedef logic [14:0] word_t;
  typedef logic [11:0] soft_addr_t;
  typedef logic [13:0] rom_addr_t;
  typedef logic [10:0] ram_addr_t;
  typedef logic [2:0]  bank_bits_t;

  // Central register select, codes 11 to 15 unused
  typedef enum logic [3:0] {
    REG_A    = 4'd0,
    REG_L    = 4'd1,
    REG_Q    = 4'd2,
    REG_EB   = 4'd3,
    REG_FB   = 4'd4,
    REG_BB   = 4'd5,
    REG_ZERO = 4'd6,
    REG_CYR  = 4'd7,
    REG_SR   = 4'd8,
    REG_CYL  = 4'd9,
    REG_SL   = 4'd10
  } reg_sel_t;

  typedef enum logic [1:0] {
    CMD_WRITE = 2'd0,
    CMD_READ  = 2'd1,
    CMD_XLATE = 2'd2
  } cmd_op_t;

  // Register access view of the payload
  typedef struct packed {
    reg_sel_t sel;
    word_t    data;
  } reg_access_t;

  // Address translation view of the payload
  typedef struct packed {
    logic       wr;
    soft_addr_t addr;
    logic [5:0] pad;
  } xlate_req_t;

  typedef union packed {
    reg_access_t reg_acc;
    xlate_req_t  xlate;
  } cmd_payload_u;

  typedef struct packed {
    cmd_op_t      op;
    cmd_payload_u payload;
  } cmd_t;

  typedef struct packed {
    word_t     data;
    rom_addr_t rom_addr;
    ram_addr_t ram_addr;
    logic      rom_hit;
    logic      write_ok;
  } rsp_t;

  // Software address map and bank geometry
  localparam soft_addr_t ROM_REGION_BASE    = 12'o2000;
  localparam soft_addr_t ROM_FIXED_BASE     = 12'o4000;
  localparam rom_addr_t  ROM_BANK_SIZE      = 14'o2000;
  localparam soft_addr_t RAM_BANKED_BASE    = 12'o1400;
  localparam ram_addr_t  RAM_BANK_SIZE      = 11'o0400;
  localparam ram_addr_t  RAM_EB_HIGH_OFFSET = 11'o2000;
  localparam rom_addr_t  ROM_IDLE_ADDR      = 14'o2000;

endpackage

// File: agc_reg_file.sv
`timescale 1ns/100ps

module agc_reg_file (
  input  logic                clk,
  input  logic                rst_l,
  input  logic                wr_en,
  input  agc_pkg::reg_sel_t   wr_sel,
  input  agc_pkg::word_t      wr_data,
  input  agc_pkg::reg_sel_t   rd_sel,
  output agc_pkg::word_t      rd_data,
  output agc_pkg::bank_bits_t eb_bits,
  output agc_pkg::bank_bits_t fb_bits
);

  import agc_pkg::*;

  word_t reg_a;
  word_t reg_l;
  word_t reg_q;
  word_t reg_cyr;
  word_t reg_sr;
  word_t reg_cyl;
  word_t reg_sl;

  // Word bits 14:12 are FB, bits 11:9 are EB
  logic [14:9] bank_q;

  always_ff @(posedge clk or negedge rst_l) begin
    if (!rst_l) begin
      reg_a   <= '0;
      reg_l   <= '0;
      reg_q   <= '0;
      reg_cyr <= '0;
      reg_sr  <= '0;
      reg_cyl <= '0;
      reg_sl  <= '0;
      bank_q  <= '0;
    end else if (wr_en) begin
      case (wr_sel)
        REG_A: reg_a <= wr_data;
        REG_L: reg_l <= wr_data;
        REG_Q: reg_q <= wr_data;
        // Bank registers only keep the bits they own
        REG_EB: bank_q[11:9]  <= wr_data[11:9];
        REG_FB: bank_q[14:12] <= wr_data[14:12];
        REG_BB: bank_q        <= wr_data[14:9];
        // Editing registers hold the shifted word
        REG_CYR: reg_cyr <= {wr_data[0], wr_data[14:1]};
        REG_SR:  reg_sr  <= {wr_data[14], wr_data[14:1]};
        REG_CYL: reg_cyl <= {wr_data[13:0], wr_data[14]};
        REG_SL:  reg_sl  <= {wr_data[13:0], 1'b0};
        // ZERO and unused codes drop the write
        default: begin
        end
      endcase
    end
  end

  always_comb begin
    case (rd_sel)
      REG_A:   rd_data = reg_a;
      REG_L:   rd_data = reg_l;
      REG_Q:   rd_data = reg_q;
      // Positional views of the shared bank store
      REG_EB:  rd_data = {3'd0, bank_q[11:9], 9'd0};
      REG_FB:  rd_data = {bank_q[14:12], 12'd0};
      REG_BB:  rd_data = {bank_q, 9'd0};
      REG_CYR: rd_data = reg_cyr;
      REG_SR:  rd_data = reg_sr;
      REG_CYL: rd_data = reg_cyl;
      REG_SL:  rd_data = reg_sl;
      REG_ZERO: rd_data = '0;
      default: rd_data = '0;
    endcase
  end

  // Bank taps for the address translators
  assign eb_bits = bank_q[11:9];
  assign fb_bits = bank_q[14:12];

endmodule

// File: agc_rom_xlate.sv
`timescale 1ns/100ps

module agc_rom_xlate (
  input  agc_pkg::soft_addr_t soft_addr,
  input  agc_pkg::bank_bits_t fb_bits,
  output agc_pkg::rom_addr_t  rom_addr
);

  import agc_pkg::*;

  rom_addr_t bank_off;
  rom_addr_t fixed_addr;
  rom_addr_t banked_addr;

  // Bank offset by table, FB times bank size
  always_comb begin
    unique case (fb_bits)
      3'd0: bank_off = '0;
      3'd1: bank_off = ROM_BANK_SIZE;
      3'd2: bank_off = rom_addr_t'(2 * ROM_BANK_SIZE);
      3'd3: bank_off = rom_addr_t'(3 * ROM_BANK_SIZE);
      3'd4: bank_off = rom_addr_t'(4 * ROM_BANK_SIZE);
      3'd5: bank_off = rom_addr_t'(5 * ROM_BANK_SIZE);
      3'd6: bank_off = rom_addr_t'(6 * ROM_BANK_SIZE);
      3'd7: bank_off = rom_addr_t'(7 * ROM_BANK_SIZE);
    endcase
  end

  // Fixed ROM sits at the bottom of physical ROM
  assign fixed_addr = rom_addr_t'(soft_addr - ROM_FIXED_BASE);

  // Banked window, skipping the fixed banks below it
  assign banked_addr = rom_addr_t'(soft_addr) + ROM_BANK_SIZE + bank_off;

  assign rom_addr = (soft_addr >= ROM_FIXED_BASE) ? fixed_addr : banked_addr;

endmodule

// File: agc_ram_xlate.sv
`timescale 1ns/100ps

module agc_ram_xlate (
  input  agc_pkg::soft_addr_t soft_addr,
  input  agc_pkg::bank_bits_t eb_bits,
  output agc_pkg::ram_addr_t  ram_addr
);

  import agc_pkg::*;

  ram_addr_t low_addr;
  ram_addr_t bank_pre;
  ram_addr_t bank_off;
  ram_addr_t banked_addr;

  assign low_addr = soft_addr[10:0];

  // Low banks from EB bits 1:0
  always_comb begin
    unique case (eb_bits[1:0])
      2'd0: bank_pre = '0;
      2'd1: bank_pre = RAM_BANK_SIZE;
      2'd2: bank_pre = ram_addr_t'(2 * RAM_BANK_SIZE);
      2'd3: bank_pre = ram_addr_t'(3 * RAM_BANK_SIZE);
    endcase
  end

  // EB bit 2 overrides the low bank select
  assign bank_off = eb_bits[2] ? RAM_EB_HIGH_OFFSET : bank_pre;

  // Wraps within 11 bits
  assign banked_addr = low_addr + bank_off;

  // Fixed erasable maps straight through
  assign ram_addr = (soft_addr < RAM_BANKED_BASE) ? low_addr : banked_addr;

endmodule

// File: agc_cmd_ctrl.sv
`timescale 1ns/100ps

module agc_cmd_ctrl (
  input  logic                clk,
  input  logic                rst_l,
  input  logic                cmd_valid,
  output logic                cmd_ready,
  input  agc_pkg::cmd_t       cmd,
  output logic                rsp_valid,
  input  logic                rsp_ready,
  output agc_pkg::rsp_t       rsp,
  output logic                wr_en,
  output agc_pkg::reg_sel_t   wr_sel,
  output agc_pkg::word_t      wr_data,
  output agc_pkg::reg_sel_t   rd_sel,
  input  agc_pkg::word_t      rd_data,
  output agc_pkg::soft_addr_t xlate_addr,
  input  agc_pkg::rom_addr_t  rom_addr,
  input  agc_pkg::ram_addr_t  ram_addr
);

  import agc_pkg::*;

  logic accept;
  logic rom_hit;
  rsp_t rsp_next;

  // Take a new command when the response slot is empty or draining
  assign cmd_ready = !rsp_valid || rsp_ready;
  assign accept    = cmd_valid && cmd_ready;

  // Register access view of the payload
  assign wr_en   = accept && (cmd.op == CMD_WRITE);
  assign wr_sel  = cmd.payload.reg_acc.sel;
  assign wr_data = cmd.payload.reg_acc.data;
  assign rd_sel  = cmd.payload.reg_acc.sel;

  // Translation view of the payload
  assign xlate_addr = cmd.payload.xlate.addr;
  assign rom_hit    = xlate_addr >= ROM_REGION_BASE;

  always_comb begin
    rsp_next = '0;
    case (cmd.op)
      CMD_READ: begin
        rsp_next.data = rd_data;
      end
      CMD_XLATE: begin
        rsp_next.rom_hit = rom_hit;
        // Idle ROM address when the access lands in erasable
        rsp_next.rom_addr = rom_hit ? rom_addr : ROM_IDLE_ADDR;
        rsp_next.ram_addr = rom_hit ? '0 : ram_addr;
        // Only erasable can be written
        rsp_next.write_ok = cmd.payload.xlate.wr && !rom_hit;
      end
      // Writes and the unused opcode answer with all zeros
      default: begin
        rsp_next = '0;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_l) begin
    if (!rst_l) begin
      rsp_valid <= 1'b0;
    end else if (cmd_ready) begin
      rsp_valid <= cmd_valid;
    end
  end

  // Held while back-pressured since accept needs cmd_ready
  always_ff @(posedge clk) begin
    if (accept) begin
      rsp <= rsp_next;
    end
  end

endmodule

// File: agc_bank_core.sv
`timescale 1ns/100ps

module agc_bank_core (
  input  logic          clk,
  input  logic          rst_l,
  input  logic          cmd_valid,
  output logic          cmd_ready,
  input  agc_pkg::cmd_t cmd,
  output logic          rsp_valid,
  input  logic          rsp_ready,
  output agc_pkg::rsp_t rsp
);

  import agc_pkg::*;

  logic       wr_en;
  reg_sel_t   wr_sel;
  word_t      wr_data;
  reg_sel_t   rd_sel;
  word_t      rd_data;
  bank_bits_t eb_bits;
  bank_bits_t fb_bits;
  soft_addr_t xlate_addr;
  rom_addr_t  rom_addr;
  ram_addr_t  ram_addr;

  agc_cmd_ctrl u_ctrl (
    .clk        (clk),
    .rst_l      (rst_l),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .cmd        (cmd),
    .rsp_valid  (rsp_valid),
    .rsp_ready  (rsp_ready),
    .rsp        (rsp),
    .wr_en      (wr_en),
    .wr_sel     (wr_sel),
    .wr_data    (wr_data),
    .rd_sel     (rd_sel),
    .rd_data    (rd_data),
    .xlate_addr (xlate_addr),
    .rom_addr   (rom_addr),
    .ram_addr   (ram_addr)
  );

  agc_reg_file u_regs (
    .clk     (clk),
    .rst_l   (rst_l),
    .wr_en   (wr_en),
    .wr_sel  (wr_sel),
    .wr_data (wr_data),
    .rd_sel  (rd_sel),
    .rd_data (rd_data),
    .eb_bits (eb_bits),
    .fb_bits (fb_bits)
  );

  // Both translators see the same software address
  agc_rom_xlate u_rom_xlate (
    .soft_addr (xlate_addr),
    .fb_bits   (fb_bits),
    .rom_addr  (rom_addr)
  );

  agc_ram_xlate u_ram_xlate (
    .soft_addr (xlate_addr),
    .eb_bits   (eb_bits),
    .ram_addr  (ram_addr)
  );

endmodule

// File: agc_bank_core_checker.sv
`timescale 1ns/100ps

module agc_bank_core_checker (
  input logic          clk,
  input logic          rst_l,
  input logic          cmd_valid,
  input logic          cmd_ready,
  input agc_pkg::cmd_t cmd,
  input logic          rsp_valid,
  input logic          rsp_ready,
  input agc_pkg::rsp_t rsp
);

  import agc_pkg::*;

  // Failed assertions, read by the testbench summary
  int fail_count = 0;

  // Response held under back-pressure
  rsp_stable_a: assert property (@(posedge clk) disable iff (!rst_l)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
    else begin
      $error("response changed while stalled");
      fail_count++;
    end

  ready_rule_a: assert property (@(posedge clk) disable iff (!rst_l)
    cmd_ready == (!rsp_valid || rsp_ready))
    else begin
      $error("cmd_ready does not follow the ready rule");
      fail_count++;
    end

  // First cycle out of reset
  reset_idle_a: assert property (@(posedge clk)
    $rose(rst_l) |-> !rsp_valid)
    else begin
      $error("rsp_valid high right after reset");
      fail_count++;
    end

  // Write answers carry nothing
  write_zero_a: assert property (@(posedge clk) disable iff (!rst_l)
    cmd_valid && cmd_ready && cmd.op == CMD_WRITE |=> rsp == '0)
    else begin
      $error("write response not all zero");
      fail_count++;
    end

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk,
  output logic rst_l
);

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Reset held low for two rising edges
  initial begin
    rst_l = 1'b0;
    repeat (2) @(posedge clk);
    #1 rst_l = 1'b1;
  end

endmodule

// File: tb_agc_bank_core.sv
`timescale 1ns/100ps

module tb_agc_bank_core;

  import agc_pkg::*;

  logic clk;
  logic rst_l;
  logic cmd_valid;
  logic cmd_ready;
  cmd_t cmd;
  logic rsp_valid;
  logic rsp_ready;
  rsp_t rsp;

  logic [15:0] lfsr;
  logic [15:0] bp_lfsr;
  logic        bp_on;
  int          mismatches;
  int          timeouts;

  // Reference model state
  word_t      model_regs [16];
  logic [5:0] model_bank;
  rsp_t       exp_q [$];

  tb_clock_gen clk_gen (.clk(clk), .rst_l(rst_l));

  agc_bank_core dut0 (
    .clk(clk), .rst_l(rst_l), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
    .cmd(cmd), .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp(rsp)
  );

  bind agc_bank_core agc_bank_core_checker u_checker (
    .clk(clk), .rst_l(rst_l), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
    .cmd(cmd), .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp(rsp)
  );

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  function automatic word_t model_read(input reg_sel_t sel);
    case (sel)
      REG_EB:  return {3'd0, model_bank[2:0], 9'd0};
      REG_FB:  return {model_bank[5:3], 12'd0};
      REG_BB:  return {model_bank, 9'd0};
      REG_A, REG_L, REG_Q, REG_CYR, REG_SR, REG_CYL, REG_SL: return model_regs[sel];
      default: return '0;
    endcase
  endfunction

  // Expected response for an accepted command, then model update
  task automatic model_accept(input cmd_t c);
    rsp_t    e;
    word_t   d;
    logic [11:0] a;
    reg_sel_t s;
    e = '0;
    s = c.payload.reg_acc.sel;
    d = c.payload.reg_acc.data;
    a = c.payload.xlate.addr;
    if (c.op == CMD_READ) begin
      e.data = model_read(s);
    end else if (c.op == CMD_XLATE) begin
      e.rom_hit = (a >= 12'o2000);
      if (e.rom_hit) begin
        if (a >= 12'o4000) e.rom_addr = 14'(a - 12'o4000);
        else e.rom_addr = 14'(a + 14'o2000 + model_bank[5:3] * 14'o2000);
      end else begin
        e.rom_addr = 14'o2000;
        if (a < 12'o1400) e.ram_addr = a[10:0];
        else if (model_bank[2]) e.ram_addr = 11'(a[10:0] + 11'o2000);
        else e.ram_addr = 11'(a[10:0] + model_bank[1:0] * 11'o400);
      end
      e.write_ok = c.payload.xlate.wr && !e.rom_hit;
    end else if (c.op == CMD_WRITE) begin
      case (s)
        REG_A, REG_L, REG_Q: model_regs[s] = d;
        REG_EB:  model_bank[2:0] = d[11:9];
        REG_FB:  model_bank[5:3] = d[14:12];
        REG_BB:  model_bank = d[14:9];
        REG_CYR: model_regs[s] = {d[0], d[14:1]};
        REG_SR:  model_regs[s] = {d[14], d[14:1]};
        REG_CYL: model_regs[s] = {d[13:0], d[14]};
        REG_SL:  model_regs[s] = {d[13:0], 1'b0};
        default: ;
      endcase
    end
    exp_q.push_back(e);
  endtask

  // Holds valid until the DUT takes the command
  task automatic send_cmd(input cmd_t c);
    int n;
    n = 0;
    cmd_valid = 1'b1;
    cmd = c;
    while (1) begin
      @(negedge clk);
      if (cmd_ready) begin
        model_accept(c);
        break;
      end
      n++;
      if (n > 100) begin
        $display("timeout at %0t: command never accepted", $time);
        timeouts++;
        break;
      end
    end
    @(posedge clk);
    #1 cmd_valid = 1'b0;
  endtask

  task automatic reg_cmd(input cmd_op_t op, input reg_sel_t sel, input word_t d);
    cmd_t c;
    c = '0;
    c.op = op;
    c.payload.reg_acc.sel = sel;
    c.payload.reg_acc.data = d;
    send_cmd(c);
  endtask

  task automatic xlate_cmd(input logic wr, input logic [11:0] a);
    cmd_t c;
    c = '0;
    c.op = CMD_XLATE;
    c.payload.xlate.wr = wr;
    c.payload.xlate.addr = a;
    send_cmd(c);
  endtask

  task automatic check_field(input string name, input logic [15:0] e, input logic [15:0] g);
    assert (e == g) else begin
      $display("mismatch at %0t: %s expected %h got %h", $time, name, e, g);
      mismatches++;
    end
  endtask

  // Responses are sampled mid-cycle
  always @(negedge clk) begin
    rsp_t e;
    if (rst_l && rsp_valid && rsp_ready) begin
      if (exp_q.size() == 0) begin
        $display("error at %0t: response with no outstanding command", $time);
        mismatches++;
      end else begin
        e = exp_q.pop_front();
        check_field("rsp.data", 16'(e.data), 16'(rsp.data));
        check_field("rsp.rom_addr", 16'(e.rom_addr), 16'(rsp.rom_addr));
        check_field("rsp.ram_addr", 16'(e.ram_addr), 16'(rsp.ram_addr));
        check_field("rsp.rom_hit", 16'(e.rom_hit), 16'(rsp.rom_hit));
        check_field("rsp.write_ok", 16'(e.write_ok), 16'(rsp.write_ok));
      end
    end
  end

  // Random back-pressure
  always @(posedge clk) begin
    #1;
    bp_lfsr = lfsr_step(bp_lfsr);
    rsp_ready = bp_on ? bp_lfsr[0] : 1'b1;
  end

  initial begin
    logic [31:0] r;
    logic [31:0] w;
    logic [11:0] bounds [5];
    int n;
    bounds = '{12'o1777, 12'o2000, 12'o3777, 12'o4000, 12'o7777};
    lfsr = 16'd77;
    bp_lfsr = 16'd77;
    bp_on = 1'b0;
    mismatches = 0;
    timeouts = 0;
    cmd_valid = 1'b0;
    cmd = '0;
    rsp_ready = 1'b1;
    model_bank = '0;
    foreach (model_regs[i]) model_regs[i] = '0;
    n = 0;
    while (!rst_l) begin
      @(posedge clk);
      n++;
      if (n > 20) begin
        $display("timeout at %0t: reset never released", $time);
        timeouts++;
        break;
      end
    end
    #1;
    // Plain registers and ZERO
    for (int s = 0; s < 3; s++) begin
      take_bits(15, r);
      reg_cmd(CMD_WRITE, reg_sel_t'(s), r[14:0]);
      reg_cmd(CMD_READ, reg_sel_t'(s), '0);
    end
    take_bits(15, r);
    reg_cmd(CMD_WRITE, REG_ZERO, r[14:0]);
    reg_cmd(CMD_READ, REG_ZERO, '0);
    // Editing registers
    for (int s = 7; s < 11; s++) begin
      take_bits(15, r);
      reg_cmd(CMD_WRITE, reg_sel_t'(s), r[14:0]);
      reg_cmd(CMD_READ, reg_sel_t'(s), '0);
    end
    // Shared bank store
    for (int k = 0; k < 3; k++) begin
      for (int s = 3; s < 6; s++) begin
        take_bits(15, r);
        reg_cmd(CMD_WRITE, reg_sel_t'(s), r[14:0]);
        reg_cmd(CMD_READ, REG_BB, '0);
        reg_cmd(CMD_READ, REG_EB, '0);
        reg_cmd(CMD_READ, REG_FB, '0);
      end
    end
    // ROM translation under several FB values
    for (int f = 0; f < 8; f += 3) begin
      reg_cmd(CMD_WRITE, REG_FB, word_t'(f << 12));
      foreach (bounds[i]) xlate_cmd(1'b1, bounds[i]);
      for (int k = 0; k < 4; k++) begin
        take_bits(13, r);
        xlate_cmd(r[12], r[11:0]);
      end
    end
    // RAM translation under every EB
    for (int e = 0; e < 8; e++) begin
      reg_cmd(CMD_WRITE, REG_EB, word_t'(e << 9));
      xlate_cmd(1'b1, 12'o1377);
      xlate_cmd(1'b1, 12'o1400);
      xlate_cmd(1'b0, 12'o0000);
      xlate_cmd(1'b1, 12'o1777);
      take_bits(12, r);
      xlate_cmd(r[11], {1'b0, r[10:0]});
    end
    // Mixed traffic under back-pressure
    bp_on = 1'b1;
    for (int k = 0; k < 80; k++) begin
      take_bits(2, w);
      take_bits(17, r);
      if (w[1:0] == 2'd2) xlate_cmd(r[16], r[11:0]);
      else reg_cmd(w[0] ? CMD_READ : CMD_WRITE, reg_sel_t'(r[16:15] + r[14:12]), r[14:0]);
    end
    bp_on = 1'b0;
    n = 0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
      n++;
      if (n > 200) begin
        $display("timeout at %0t: %0d responses never arrived", $time, exp_q.size());
        timeouts++;
        break;
      end
    end
    $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
             mismatches, timeouts, dut0.u_checker.fail_count);
    if (mismatches == 0 && timeouts == 0 && dut0.u_checker.fail_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: all.f
agc_pkg.sv
agc_reg_file.sv
agc_rom_xlate.sv
agc_ram_xlate.sv
agc_cmd_ctrl.sv
agc_bank_core.sv
agc_bank_core_checker.sv
tb_clock_gen.sv
tb_agc_bank_core.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_agc_bank_core
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_agc_bank_core 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^Test OK$"; then
  exit 0
fi
exit 1
